// File: riscvPkg.sv
package riscvPkg;

    // RV32I base ISA constants shared by the fetch-side blocks

    // Machine word
    localparam int xlen = 32;                          // PC and data width
    localparam int instrWidth = 32;                    // No compressed instructions

    // Major opcode of the B-type group (beq, bne, blt, bge, bltu, bgeu)
    localparam logic [6:0] opcodeBranch = 7'b1100011;  // Conditional branch

    // Fall-through step for a 32-bit instruction
    localparam logic [xlen-1:0] pcStep = 32'd4;        // Bytes per instruction

    // Field positions used by the B-type decoder
    localparam int opcodeLsb = 0;                      // instr[6:0]
    localparam int opcodeMsb = 6;
    localparam int signBit = instrWidth - 1;           // instr[31], imm[12]

    // Width of the sign extension in front of the 13-bit immediate
    localparam int immSignExt = xlen - 13;             // 19 copies of imm[12]

endpackage

// File: bpuPkg.sv
package bpuPkg;

    // Direction predictor and in-flight queue constants

    // Saturating direction counters
    // 00 strong not taken, 01 weak not taken, 10 weak taken, 11 strong taken
    localparam int counterWidth = 2;                                   // Bits per counter
    localparam logic [counterWidth-1:0] counterInit = 2'b10;           // Weakly taken
    localparam logic [counterWidth-1:0] counterMax = 2'd3;             // Saturate high
    localparam logic [counterWidth-1:0] counterMin = 2'd0;             // Saturate low
    localparam logic [counterWidth-1:0] takenThreshold = 2'd2;         // Predict taken at or above

    // In-flight record queue
    // Holds branches between fetch and execute; depth covers the
    // pipeline distance, so the environment never overfills it
    localparam int queueDepth = 4;                                     // Records in flight
    localparam int queuePtrWidth = 2;                                  // log2(queueDepth)

    // Occupancy needs one bit more than a pointer to tell full from empty
    localparam int queueCountWidth = queuePtrWidth + 1;
    localparam logic [queueCountWidth-1:0] queueFullCount =
        queueCountWidth'(queueDepth);                                  // Count when full

endpackage

// File: branchDecode.sv
`timescale 1ns/100ps

module branchDecode import riscvPkg::*; (
    input  logic                  fetchValid,   // Fetch strobe
    input  logic [instrWidth-1:0] instr,        // Fetched instruction
    input  logic [xlen-1:0]       pcF,          // Address of instr
    output logic                  isBranch,     // Valid conditional branch
    output logic [xlen-1:0]       branchTarget, // pcF plus B-type offset
    output logic                  backward      // Negative offset
);

    logic [6:0]      opcode;    // Major opcode field
    logic [xlen-1:0] immB;      // Sign-extended B-type immediate

    assign opcode = instr[opcodeMsb:opcodeLsb];

    // Only a strobed word with the branch opcode counts
    // funct3 is not checked, all six B-type encodings share the same path
    assign isBranch = fetchValid && (opcode == opcodeBranch);

    // B-type immediate is scattered over the instruction word
    //   imm[12]   = instr[31]
    //   imm[11]   = instr[7]
    //   imm[10:5] = instr[30:25]
    //   imm[4:1]  = instr[11:8]
    //   imm[0]    = 0, targets are halfword aligned
    always_comb begin
        immB = {
            {immSignExt{instr[signBit]}}, // Sign extension
            instr[signBit],               // imm[12]
            instr[7],                     // imm[11]
            instr[30:25],                 // imm[10:5]
            instr[11:8],                  // imm[4:1]
            1'b0                          // imm[0]
        };
    end

    // Target is PC relative
    assign branchTarget = pcF + immB;

    // Sign of the offset picks the counter, loops branch backward
    assign backward = immB[xlen-1];

endmodule

// File: directionPredictor.sv
`timescale 1ns/100ps

module directionPredictor import bpuPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic backward,       // Direction of the fetched branch
    input  logic trainValid,     // Resolved branch this cycle
    input  logic trainBackward,  // Direction of the resolved branch
    input  logic trainTaken,     // Actual outcome, 1 = taken
    output logic predictTaken    // Prediction for the fetched branch
);

    logic [counterWidth-1:0] forwardCount;   // Forward branch counter
    logic [counterWidth-1:0] backwardCount;  // Backward branch counter
    logic [counterWidth-1:0] selCount;       // Counter read by fetch

    // One saturating step toward the actual outcome
    function automatic logic [counterWidth-1:0] stepCount(
        input logic [counterWidth-1:0] count,
        input logic                    taken
    );
        logic [counterWidth-1:0] next;
        next = count;
        if (taken) begin
            if (count != counterMax) next = count + 1'b1;  // Stop at strong taken
        end else begin
            if (count != counterMin) next = count - 1'b1;  // Stop at strong not taken
        end
        return next;
    endfunction

    // Read uses the value held before this cycle's training
    assign selCount = backward ? backwardCount : forwardCount;
    assign predictTaken = (selCount >= takenThreshold);  // Upper half predicts taken

    // Training lands at the next edge
    always_ff @(posedge clk) begin
        if (!rstN) begin
            forwardCount <= counterInit;   // Weakly taken
            backwardCount <= counterInit;
        end else if (trainValid) begin
            if (trainBackward) begin
                backwardCount <= stepCount(backwardCount, trainTaken);
            end else begin
                forwardCount <= stepCount(forwardCount, trainTaken);
            end
        end
    end

    // Only one counter moves per resolve, the other keeps its state
    // A single not-taken from strong taken still leaves the upper half

endmodule

// File: branchQueue.sv
`timescale 1ns/100ps

module branchQueue import riscvPkg::*; import bpuPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic            push,          // Record a fetched branch
    input  logic [xlen-1:0] pushAddr,      // Branch address
    input  logic [xlen-1:0] pushTarget,    // Taken target
    input  logic            pushBackward,  // Direction
    input  logic            pushPredict,   // Prediction made at fetch
    input  logic            pop,           // Oldest branch resolved
    input  logic            clear,         // Drop all records
    output logic [xlen-1:0] headAddr,      // Oldest record fields
    output logic [xlen-1:0] headTarget,
    output logic            headBackward,
    output logic            headPredict,
    output logic            empty,
    output logic            full
);

    // Record storage, one slot per in-flight branch
    logic [xlen-1:0] addrMem [queueDepth];
    logic [xlen-1:0] targetMem [queueDepth];
    logic            backwardMem [queueDepth];
    logic            predictMem [queueDepth];

    logic [queuePtrWidth-1:0]   wrPtr;   // Next free slot
    logic [queuePtrWidth-1:0]   rdPtr;   // Oldest record
    logic [queueCountWidth-1:0] count;   // Occupancy

    assign empty = (count == '0);
    assign full = (count == queueFullCount);

    // Head is read straight from storage, no extra cycle
    assign headAddr = addrMem[rdPtr];
    assign headTarget = targetMem[rdPtr];
    assign headBackward = backwardMem[rdPtr];
    assign headPredict = predictMem[rdPtr];

    // Payload write, pointers decide what is valid
    always_ff @(posedge clk) begin
        if (push && !clear) begin
            addrMem[wrPtr] <= pushAddr;
            targetMem[wrPtr] <= pushTarget;
            backwardMem[wrPtr] <= pushBackward;
            predictMem[wrPtr] <= pushPredict;
        end
    end

    // Pointers and count; clear beats push and pop
    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= wrPtr + 1'b1;  // Wraps at queueDepth
            if (pop) rdPtr <= rdPtr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase
        end
    end

endmodule

// File: branchResolve.sv
`timescale 1ns/100ps

module branchResolve import riscvPkg::*; (
    input  logic            branchE,        // Oldest branch resolved
    input  logic            zeroE,          // Actual outcome, 1 = taken
    input  logic [xlen-1:0] headAddr,       // Oldest record from queue
    input  logic [xlen-1:0] headTarget,
    input  logic            headBackward,
    input  logic            headPredict,
    output logic            mispredict,     // Prediction was wrong
    output logic [xlen-1:0] correctPc,      // Where fetch should be
    output logic            trainValid,     // Update a counter
    output logic            trainBackward,  // Which counter
    output logic            trainTaken      // Direction to step
);

    logic [xlen-1:0] fallThrough;  // Branch address plus one instruction
    logic            wrongDir;     // Head prediction differs from outcome

    assign fallThrough = headAddr + pcStep;
    assign wrongDir = (headPredict != zeroE);

    // Only meaningful with a strobe, the head is stale otherwise
    assign mispredict = branchE && wrongDir;

    // Actual path, regardless of what was predicted
    // Taken goes to the target, not taken to the next word
    always_comb begin
        if (zeroE) begin
            correctPc = headTarget;
        end else begin
            correctPc = fallThrough;
        end
    end

    // Every resolve trains, right or wrong
    assign trainValid = branchE;
    assign trainBackward = headBackward;  // Counter chosen at fetch
    assign trainTaken = zeroE;            // Step toward the outcome

    // Execute resolves in program order, so the head is always the
    // record that matches this strobe

endmodule

// File: branchPredictUnit.sv
`timescale 1ns/100ps

module branchPredictUnit import riscvPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  fetchValid,   // Fetch strobe
    input  logic [instrWidth-1:0] instr,        // Fetched instruction
    input  logic [xlen-1:0]       pcF,          // Fetch address
    input  logic                  branchE,      // Execute resolve strobe
    input  logic                  zeroE,        // Resolved outcome
    output logic                  flushBranch,  // Flush younger stages
    output logic [xlen-1:0]       pcBpu,        // Redirect address
    output logic                  pcBpuSrc      // Select pcBpu for fetch
);

    logic            isBranch;       // Decode results
    logic [xlen-1:0] branchTarget;
    logic            backward;
    logic            predictTaken;   // Predictor output
    logic            pushValid;      // Branch kept in the queue
    logic [xlen-1:0] headAddr;       // Queue head
    logic [xlen-1:0] headTarget;
    logic            headBackward;
    logic            headPredict;
    logic            queueEmpty;     // Occupancy flags
    logic            queueFull;
    logic            mispredict;     // Resolve results
    logic [xlen-1:0] correctPc;
    logic            trainValid;
    logic            trainBackward;
    logic            trainTaken;

    branchDecode u_decode (.fetchValid(fetchValid), .instr(instr), .pcF(pcF),
        .isBranch(isBranch), .branchTarget(branchTarget), .backward(backward));

    directionPredictor u_predictor (.clk(clk), .rstN(rstN), .backward(backward),
        .trainValid(trainValid), .trainBackward(trainBackward), .trainTaken(trainTaken),
        .predictTaken(predictTaken));

    // Same-cycle fetch is wrong-path when the older branch missed
    assign pushValid = isBranch && !mispredict;

    branchQueue u_queue (.clk(clk), .rstN(rstN), .push(pushValid), .pushAddr(pcF),
        .pushTarget(branchTarget), .pushBackward(backward), .pushPredict(predictTaken),
        .pop(branchE), .clear(mispredict), .headAddr(headAddr), .headTarget(headTarget),
        .headBackward(headBackward), .headPredict(headPredict), .empty(queueEmpty),
        .full(queueFull));

    branchResolve u_resolve (.branchE(branchE), .zeroE(zeroE), .headAddr(headAddr),
        .headTarget(headTarget), .headBackward(headBackward), .headPredict(headPredict),
        .mispredict(mispredict), .correctPc(correctPc), .trainValid(trainValid),
        .trainBackward(trainBackward), .trainTaken(trainTaken));

    // Output register, mispredict first since it is older
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcBpu <= '0;
            pcBpuSrc <= 1'b0;
            flushBranch <= 1'b0;
        end else if (mispredict) begin
            pcBpu <= correctPc;             // Recover to actual path
            pcBpuSrc <= 1'b1;
            flushBranch <= 1'b1;
        end else if (pushValid && predictTaken) begin
            pcBpu <= branchTarget;          // Early redirect at fetch
            pcBpuSrc <= 1'b1;
            flushBranch <= 1'b1;            // Drop fall-through
        end else begin
            pcBpu <= '0;                    // No redirect
            pcBpuSrc <= 1'b0;
            flushBranch <= 1'b0;
        end
    end

endmodule

// File: tbClock.sv
`timescale 1ns/100ps

module tbClock (
    output logic clk    // Free-running testbench clock
);

    initial begin
        clk = 1'b0;     // Known level before the first edge
    end

    // 8 ns period, rising edges at 4, 12, 20 ns
    always begin
        #4 clk = ~clk;  // Half period
    end

endmodule

// File: branchPredictUnit_assertions.sv
`timescale 1ns/100ps

module branchPredictUnitAssertions import riscvPkg::*; (
    input logic            clk,
    input logic            rstN,
    input logic            fetchValid,   // Fetch strobe
    input logic            branchE,      // Resolve strobe, pops the queue
    input logic            pushValid,    // Queue push after mispredict gating
    input logic            queueEmpty,
    input logic            queueFull,
    input logic            flushBranch,
    input logic            pcBpuSrc,
    input logic [xlen-1:0] pcBpu
);

    int failCount = 0;  // Failed assertions so far

    // Execute only resolves branches that fetch recorded
    popNotEmpty: assert property (@(posedge clk) disable iff (!rstN)
        branchE |-> !queueEmpty)
        else begin
            $error("Resolve strobe while the branch queue is empty");
            failCount++;
        end

    // No more than queueDepth branches in flight
    pushNotFull: assert property (@(posedge clk) disable iff (!rstN)
        pushValid |-> !queueFull)
        else begin
            $error("Branch pushed while the branch queue is full");
            failCount++;
        end

    // A redirect comes with a flush and follows a fetch or resolve strobe
    redirectWithFlush: assert property (@(posedge clk) disable iff (!rstN)
        (pcBpuSrc == flushBranch) && (!pcBpuSrc || $past(branchE || fetchValid)))
        else begin
            $error("Redirect without a flush or without a strobe on the cycle before");
            failCount++;
        end

    // Registered outputs clear one edge after reset is seen
    quietInReset: assert property (@(posedge clk)
        !rstN |=> (!pcBpuSrc && !flushBranch && pcBpu == '0))
        else begin
            $error("Redirect outputs not cleared by reset");
            failCount++;
        end

endmodule

bind branchPredictUnit branchPredictUnitAssertions u_assertions (
    .clk(clk), .rstN(rstN), .fetchValid(fetchValid), .branchE(branchE),
    .pushValid(pushValid), .queueEmpty(queueEmpty), .queueFull(queueFull),
    .flushBranch(flushBranch), .pcBpuSrc(pcBpuSrc), .pcBpu(pcBpu));

// File: tbBranchPredictUnit.sv
`timescale 1ns/100ps

module tbBranchPredictUnit import riscvPkg::*; import bpuPkg::*; ();

    localparam int fieldsPerRow = 6;     // test, fetchValid, instr, pcF, branchE, zeroE
    localparam int maxRows = 64;
    localparam int maxIdle = 3;          // Idle cycles after a row, 1 to maxIdle
    localparam int resetCycles = 8;
    localparam int marginCycles = 20;

    logic                  clk;
    logic                  rstN;
    logic                  fetchValid;
    logic [instrWidth-1:0] instr;
    logic [xlen-1:0]       pcF;
    logic                  branchE;
    logic                  zeroE;
    logic                  flushBranch;
    logic [xlen-1:0]       pcBpu;
    logic                  pcBpuSrc;

    logic [31:0] patMem [fieldsPerRow*maxRows];  // Raw pattern words

    // Reference model state
    logic [xlen-1:0] modelAddr [$];      // In-flight records, oldest first
    logic [xlen-1:0] modelTarget [$];
    logic            modelBackward [$];
    logic            modelPredict [$];
    int              fwdCount;           // Forward counter
    int              bwdCount;           // Backward counter
    logic [xlen-1:0] expPc;              // Expected registered outputs
    logic            expSrc;
    logic            expFlush;

    int rowCount;
    int cycleCount;
    int cycleLimit;                      // 0 until the rows are counted
    int errorCount;
    int checkCount;
    int testCount;
    int curTest;
    int testRows;
    int testErrors;

    tbClock u_clock (.clk(clk));

    branchPredictUnit u_dut (.clk(clk), .rstN(rstN), .fetchValid(fetchValid), .instr(instr),
        .pcF(pcF), .branchE(branchE), .zeroE(zeroE), .flushBranch(flushBranch),
        .pcBpu(pcBpu), .pcBpuSrc(pcBpuSrc));

    // B-type offset from the scattered immediate fields
    function automatic logic [xlen-1:0] decodeOffset(input logic [instrWidth-1:0] word);
        return {{(xlen-13){word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    endfunction

    // Two-bit counter moves toward the outcome, clamped at both ends
    function automatic int stepToward(input int count, input logic taken);
        if (taken && count < int'(counterMax)) return count + 1;
        if (!taken && count > 0) return count - 1;
        return count;
    endfunction

    task automatic countError();
        errorCount++;
        testErrors++;
    endtask

    // Expected outputs for one row, updates model state
    task automatic modelRow(input logic fv, input logic [31:0] word, input logic [31:0] pc,
                            input logic be, input logic z);
        logic            isBr;
        logic [xlen-1:0] offset;
        logic            back;
        logic            pred;
        logic            mis;
        logic [xlen-1:0] correct;
        logic [xlen-1:0] hAddr;
        logic [xlen-1:0] hTarget;
        logic            hBackward;
        logic            hPredict;
        isBr = fv && (word[6:0] == opcodeBranch);
        offset = decodeOffset(word);
        back = offset[xlen-1];                                    // Negative offset
        pred = ((back ? bwdCount : fwdCount) >= int'(takenThreshold)); // Before training
        mis = 1'b0;
        correct = '0;
        if (be) begin
            if (modelAddr.size() == 0) begin
                $display("Pattern resolves a branch at %0t with none in flight", $time);
                countError();
            end else begin
                hAddr = modelAddr.pop_front();
                hTarget = modelTarget.pop_front();
                hBackward = modelBackward.pop_front();
                hPredict = modelPredict.pop_front();
                mis = (hPredict != z);
                correct = z ? hTarget : hAddr + pcStep;           // Actual path
                if (hBackward) bwdCount = stepToward(bwdCount, z);
                else fwdCount = stepToward(fwdCount, z);
            end
        end
        if (mis) begin
            modelAddr.delete();                                   // Younger records are wrong-path
            modelTarget.delete();
            modelBackward.delete();
            modelPredict.delete();
            expPc = correct;
            expSrc = 1'b1;
            expFlush = 1'b1;
        end else if (isBr) begin
            modelAddr.push_back(pc);
            modelTarget.push_back(pc + offset);
            modelBackward.push_back(back);
            modelPredict.push_back(pred);
            if (modelAddr.size() > queueDepth) begin
                $display("Pattern has more than %0d branches in flight at %0t", queueDepth, $time);
                countError();
            end
            expPc = pred ? pc + offset : '0;
            expSrc = pred;
            expFlush = pred;
        end else begin
            expPc = '0;                                           // No redirect
            expSrc = 1'b0;
            expFlush = 1'b0;
        end
    endtask

    task automatic checkOutputs();
        checkCount++;
        assert (pcBpu === expPc) else begin
            $display("FAIL %0t pcBpu expected %h got %h", $time, expPc, pcBpu);
            countError();
        end
        assert (pcBpuSrc === expSrc) else begin
            $display("FAIL %0t pcBpuSrc expected %b got %b", $time, expSrc, pcBpuSrc);
            countError();
        end
        assert (flushBranch === expFlush) else begin
            $display("FAIL %0t flushBranch expected %b got %b", $time, expFlush, flushBranch);
            countError();
        end
    endtask

    task automatic reportTest();
        $display("Test %0d finished: %0d rows, %0d errors", curTest, testRows, testErrors);
        testCount++;
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the patterns did not complete", cycleCount);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int base;
        int gap;
        void'($urandom(32'hcccbe56a));   // Single seed for the idle gaps
        rstN = 1'b0;
        fetchValid = 1'b0;
        instr = '0;
        pcF = '0;
        branchE = 1'b0;
        zeroE = 1'b0;
        cycleCount = 0;
        cycleLimit = 0;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        fwdCount = counterInit;          // Matches DUT reset state
        bwdCount = counterInit;
        for (int i = 0; i < fieldsPerRow*maxRows; i++) patMem[i] = '1;  // End marker
        $readmemh("branchPatterns.txt", patMem);
        rowCount = 0;
        while (rowCount < maxRows && patMem[rowCount*fieldsPerRow] !== 32'hffffffff) rowCount++;
        cycleLimit = rowCount*(1 + maxIdle) + resetCycles + marginCycles;

        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        if (rowCount == 0) begin
            $display("Pattern file holds no rows");
            errorCount++;
        end else begin
            curTest = patMem[0];
            testRows = 0;
            testErrors = 0;
            for (int row = 0; row < rowCount; row++) begin
                base = row*fieldsPerRow;
                if (patMem[base] != curTest) begin
                    reportTest();
                    curTest = patMem[base];
                    testRows = 0;
                    testErrors = 0;
                end
                @(posedge clk);
                fetchValid <= patMem[base+1][0];
                instr <= patMem[base+2];
                pcF <= patMem[base+3];
                branchE <= patMem[base+4][0];
                zeroE <= patMem[base+5][0];
                modelRow(patMem[base+1][0], patMem[base+2], patMem[base+3],
                         patMem[base+4][0], patMem[base+5][0]);
                @(posedge clk);          // DUT registers the row
                fetchValid <= 1'b0;
                instr <= '0;
                pcF <= '0;
                branchE <= 1'b0;
                zeroE <= 1'b0;
                @(negedge clk);          // Outputs settled
                checkOutputs();
                testRows++;
                gap = $urandom % maxIdle;
                repeat (gap) @(posedge clk);
            end
            reportTest();
        end

        errorCount += u_dut.u_assertions.failCount;  // Protocol assertion failures
        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
riscvPkg.sv
bpuPkg.sv
branchDecode.sv
directionPredictor.sv
branchQueue.sv
branchResolve.sv
branchPredictUnit.sv
tbClock.sv
branchPredictUnit_assertions.sv
tbBranchPredictUnit.sv

// File: branchPatterns.txt
// test fetchValid instr pcF branchE zeroE, all hex, one row per driven cycle
// zeroE is the actual outcome of the oldest in-flight branch, 1 = taken
1 1 00100093 00000100 0 0
1 0 00000863 00000104 0 0
1 1 00002083 00000108 0 0
2 1 00000863 00000200 0 0
2 0 00000000 00000000 1 1
2 1 FE000CE3 00000300 0 0
2 0 00000000 00000000 1 1
2 1 000000E3 00001000 0 0
2 0 00000000 00000000 1 1
3 1 10209063 00002000 0 0
3 0 00000000 00000000 1 0
3 1 10209063 00002000 0 0
3 0 00000000 00000000 1 0
3 1 10209063 00002000 0 0
3 0 00000000 00000000 1 0
3 1 10209063 00002000 0 0
3 0 00000000 00000000 1 0
3 1 FE0000E3 00003000 0 0
3 0 00000000 00000000 1 1
3 1 FE0000E3 00003000 0 0
3 0 00000000 00000000 1 0
3 1 FE0000E3 00003000 0 0
3 0 00000000 00000000 1 1
4 1 00000863 00004000 0 0
4 0 00000000 00000000 1 1
4 1 FE000CE3 00004100 0 0
4 0 00000000 00000000 1 0
5 1 00000863 00005000 0 0
5 1 FE000CE3 00005100 0 0
5 1 10000063 00005200 0 0
5 0 00000000 00000000 1 0
5 1 FE0000E3 00005300 1 1
5 1 00000863 00005400 1 1
5 1 FE000CE3 00005300 0 0
5 0 00000000 00000000 1 1
